/* list.f */
+incdir+verification
logic/rename_pkg.sv
logic/rename_if.sv
logic/free_list.sv
logic/map_table.sv
logic/reorder_buffer.sv
logic/rename_core.sv
verification/rename_core_tb.sv

/* Makefile */
# Verilator build and run for the rename core testbench

VERILATOR ?= verilator
TOP ?= rename_core_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timescale 1ns/100ps -j 0

SOURCES := $(wildcard logic/*.sv verification/*.sv verification/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# exit status of the binary is the verdict
run: $(BIN)
	$(BIN)

clean:
	rm -rf $(BUILD_DIR)

/* verification/rename_model.svh */
// rename_model: expected map table, free FIFO and in-flight entry queue for the testbench
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// expected ARN to PRN mapping
prn_t map_ref [num_arch_regs];

// expected free PRNs, next one out at index 0
prn_t free_ref [$];

// expected entries, indexed by ROB slot
arn_t arn_ref [rob_depth];
logic reg_write_ref [rob_depth];
prn_t prn_ref [rob_depth];
prn_t old_prn_ref [rob_depth];
logic done_ref [rob_depth];

// oldest slot, next slot, occupancy
int head_ref;
int tail_ref;
int count_ref;

// contents right after reset
task automatic reset_model();
	free_ref.delete();
	for (int i = 0; i < num_arch_regs; i++) begin
		map_ref[i] = prn_t'(i);
	end
	// identity map leaves the top PRNs unused
	for (int i = num_arch_regs; i < num_phys_regs; i++) begin
		free_ref.push_back(prn_t'(i));
	end
	for (int i = 0; i < rob_depth; i++) begin
		done_ref[i] = 1'b0;
	end
	head_ref = 0;
	tail_ref = 0;
	count_ref = 0;
endtask

// room in the queue, and a PRN for writers
function automatic logic can_dispatch(input logic reg_write);
	return (count_ref < rob_depth) && ((free_ref.size() != 0) || !reg_write);
endfunction

// oldest entry seen completed
function automatic logic head_done();
	return (count_ref != 0) && done_ref[head_ref];
endfunction

// rename and enqueue one accepted instruction
task automatic accept_dispatch(input arn_t arn, input logic reg_write);
	arn_ref[tail_ref] = arn;
	reg_write_ref[tail_ref] = reg_write;
	old_prn_ref[tail_ref] = map_ref[arn];
	done_ref[tail_ref] = 1'b0;
	if (reg_write) begin
		prn_ref[tail_ref] = free_ref.pop_front();
		map_ref[arn] = prn_ref[tail_ref];
	end
	tail_ref = (tail_ref + 1) % rob_depth;
	count_ref++;
endtask

// oldest entry leaves, superseded PRN goes to the back of the FIFO
task automatic retire_oldest();
	if (reg_write_ref[head_ref]) begin
		free_ref.push_back(old_prn_ref[head_ref]);
	end
	done_ref[head_ref] = 1'b0;
	head_ref = (head_ref + 1) % rob_depth;
	count_ref--;
endtask

`endif

/* verification/rename_core_tb.sv */
// rename_core_tb: clock, reset, LFSR stimulus, model checks, timeout and verdict for rename_core
module rename_core_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import rename_pkg::*;

	localparam int num_attempts = 3000;
	// one attempt every other cycle on average, about 6000 cycles
	localparam int max_cycles = 20000;

	logic clock;
	logic rst_n;
	logic dispatch_valid;
	logic dispatch_ready;
	arn_t dispatch_arn;
	logic dispatch_reg_write;
	prn_t dispatch_prn;
	prn_t dispatch_old_prn;
	rob_idx_t dispatch_rob_idx;
	logic complete_valid;
	rob_idx_t complete_rob_idx;
	logic retire_valid;
	logic retire_ready;
	arn_t retire_arn;
	logic retire_reg_write;
	prn_t retire_prn;
	prn_t retire_old_prn;

	logic [31:0] lfsr_state;
	int cycle_count;
	int attempts;
	int retired;

	// retire outputs from a stalled cycle
	logic held;
	arn_t held_arn;
	logic held_reg_write;
	prn_t held_prn;
	prn_t held_old_prn;

	// slots still waiting for completion
	int busy [$];

	`include "rename_model.svh"

	rename_core i_rename_core (.*);

	always #2 clock = ~clock;

	////////////////////
	// helpers
	////////////////////

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			$display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
			$display("Simulation FAILED");
			$fatal(1, "%s differs from the model", what);
		end
	endtask

	task automatic observe_dispatch();
		check_equal(32'(dispatch_ready), 32'(can_dispatch(dispatch_reg_write)), "dispatch_ready");
		if (dispatch_valid) begin
			attempts++;
		end
		if (dispatch_valid && dispatch_ready) begin
			check_equal(32'(dispatch_rob_idx), 32'(tail_ref), "dispatch_rob_idx");
			check_equal(32'(dispatch_old_prn), 32'(map_ref[dispatch_arn]), "dispatch_old_prn");
			// only writers take the free-list head
			if (dispatch_reg_write) begin
				check_equal(32'(dispatch_prn), 32'(free_ref[0]), "dispatch_prn");
			end
			accept_dispatch(dispatch_arn, dispatch_reg_write);
		end
	endtask

	task automatic observe_retire();
		check_equal(32'(retire_valid), 32'(head_done()), "retire_valid");
		// stalled head stays put
		if (held) begin
			check_equal(32'(retire_arn), 32'(held_arn), "stalled retire_arn");
			check_equal(32'(retire_reg_write), 32'(held_reg_write), "stalled retire_reg_write");
			check_equal(32'(retire_prn), 32'(held_prn), "stalled retire_prn");
			check_equal(32'(retire_old_prn), 32'(held_old_prn), "stalled retire_old_prn");
		end
		if (retire_valid) begin
			check_equal(32'(retire_arn), 32'(arn_ref[head_ref]), "retire_arn");
			check_equal(32'(retire_reg_write), 32'(reg_write_ref[head_ref]), "retire_reg_write");
			check_equal(32'(retire_old_prn), 32'(old_prn_ref[head_ref]), "retire_old_prn");
			if (retire_reg_write) begin
				check_equal(32'(retire_prn), 32'(prn_ref[head_ref]), "retire_prn");
			end
		end
		held = retire_valid && !retire_ready;
		held_arn = retire_arn;
		held_reg_write = retire_reg_write;
		held_prn = retire_prn;
		held_old_prn = retire_old_prn;
		if (retire_valid && retire_ready) begin
			retire_oldest();
			retired++;
		end
	endtask

	task automatic drive_inputs();
		int pick;
		busy.delete();
		for (int k = 0; k < count_ref; k++) begin
			if (!done_ref[(head_ref + k) % rob_depth]) begin
				busy.push_back((head_ref + k) % rob_depth);
			end
		end
		dispatch_valid <= take_bits(1) != 0;
		dispatch_arn <= arn_t'(take_bits(5));
		// mostly writers, so the free list runs dry
		dispatch_reg_write <= take_bits(2) != 0;
		// 96-cycle stall every 256 cycles fills the buffer
		retire_ready <= (take_bits(2) != 0) && (cycle_count % 256 < 160);
		complete_valid <= 1'b0;
		if (busy.size() != 0) begin
			if (take_bits(1) != 0) begin
				// any busy slot, not just the oldest
				pick = int'(take_bits(4)) % busy.size();
				complete_valid <= 1'b1;
				complete_rob_idx <= rob_idx_t'(busy[pick]);
			end
		end
	endtask

	task automatic report_verdict();
		if (retired == 0) begin
			$display("Simulation FAILED");
			$fatal(1, "no instruction retired during the run");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	endtask

	////////////////////
	// run
	////////////////////

	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_arn = '0;
		dispatch_reg_write = 1'b0;
		complete_valid = 1'b0;
		complete_rob_idx = '0;
		retire_ready = 1'b0;
		lfsr_state = 32'hcfb18875;
		cycle_count = 0;
		attempts = 0;
		retired = 0;
		held = 1'b0;
		reset_model();
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;
	end

	// sample pre-edge values, update the model, then drive the next cycle
	always @(posedge clock) begin
		if (rst_n) begin
			cycle_count++;
			if (cycle_count >= max_cycles) begin
				$display("Simulation FAILED");
				$fatal(1, "timeout after %0d cycles with %0d attempts made", cycle_count, attempts);
			end else begin
				observe_dispatch();
				observe_retire();
				// completion counts from the next cycle on
				if (complete_valid) begin
					done_ref[complete_rob_idx] = 1'b1;
				end
				if (attempts >= num_attempts) begin
					report_verdict();
				end else begin
					drive_inputs();
				end
			end
		end
	end

endmodule

/* logic/rename_core.sv */
// rename_core: top level joining free list, map table and reorder buffer to plain ports
module rename_core (
	input logic clock,
	input logic rst_n,

	// dispatch
	input logic dispatch_valid,
	output logic dispatch_ready,
	input rename_pkg::arn_t dispatch_arn,
	input logic dispatch_reg_write,
	output rename_pkg::prn_t dispatch_prn,
	output rename_pkg::prn_t dispatch_old_prn,
	output rename_pkg::rob_idx_t dispatch_rob_idx,

	// completion bus is always accepted
	input logic complete_valid,
	input rename_pkg::rob_idx_t complete_rob_idx,

	// in-order retirement
	output logic retire_valid,
	input logic retire_ready,
	output rename_pkg::arn_t retire_arn,
	output logic retire_reg_write,
	output rename_pkg::prn_t retire_prn,
	output rename_pkg::prn_t retire_old_prn
);

	import rename_pkg::*;

	// free list status into dispatch acceptance
	logic free_empty;

	// retirement returns a PRN to the free list
	logic release_valid;
	prn_t release_prn;

	//////////////////////
	// rename bundle
	//////////////////////

	rename_if rn ();

	assign rn.arn = dispatch_arn;
	assign rn.reg_write = dispatch_reg_write;

	// rename results straight out in the dispatch cycle
	assign dispatch_prn = rn.new_prn;
	assign dispatch_old_prn = rn.old_prn;

	//////////////////////
	// blocks
	//////////////////////

	free_list i_free_list (
		.clock(clock),
		.rst_n(rst_n),
		.pool(rn.pool),
		.free_empty(free_empty),
		.release_valid(release_valid),
		.release_prn(release_prn)
	);

	map_table i_map_table (
		.clock(clock),
		.rst_n(rst_n),
		.map(rn.map)
	);

	reorder_buffer i_reorder_buffer (
		.clock(clock),
		.rst_n(rst_n),
		.rob(rn.rob),
		.dispatch_valid(dispatch_valid),
		.dispatch_ready(dispatch_ready),
		.dispatch_rob_idx(dispatch_rob_idx),
		.free_empty(free_empty),
		.complete_valid(complete_valid),
		.complete_rob_idx(complete_rob_idx),
		.retire_valid(retire_valid),
		.retire_ready(retire_ready),
		.retire_arn(retire_arn),
		.retire_reg_write(retire_reg_write),
		.retire_prn(retire_prn),
		.retire_old_prn(retire_old_prn),
		.release_valid(release_valid),
		.release_prn(release_prn)
	);

endmodule

/* logic/reorder_buffer.sv */
// reorder_buffer: circular entry store with dispatch acceptance, completion and in-order retirement
module reorder_buffer (
	input logic clock,
	input logic rst_n,
	rename_if.rob rob,
	input logic dispatch_valid,
	output logic dispatch_ready,
	output rename_pkg::rob_idx_t dispatch_rob_idx,
	input logic free_empty,
	input logic complete_valid,
	input rename_pkg::rob_idx_t complete_rob_idx,
	output logic retire_valid,
	input logic retire_ready,
	output rename_pkg::arn_t retire_arn,
	output logic retire_reg_write,
	output rename_pkg::prn_t retire_prn,
	output rename_pkg::prn_t retire_old_prn,
	output logic release_valid,
	output rename_pkg::prn_t release_prn
);

	import rename_pkg::*;

	// per-entry state
	entry_state_t state_q [rob_depth];

	// per-entry payload
	arn_t arn_q [rob_depth];
	logic reg_write_q [rob_depth];
	prn_t prn_q [rob_depth];
	prn_t old_prn_q [rob_depth];

	// oldest entry, next free slot, occupancy
	rob_idx_t head_q;
	rob_idx_t tail_q;
	rob_count_t count_q;

	logic rob_full;
	logic retire_fire;

	//////////////////////
	// dispatch
	//////////////////////

	assign rob_full = (count_q == rob_count_t'(rob_depth));

	// writers also need a PRN from the free list
	assign dispatch_ready = !rob_full && !(rob.reg_write && free_empty);
	assign rob.fire = dispatch_valid && dispatch_ready;

	// new entry lands on the tail
	assign dispatch_rob_idx = tail_q;

	//////////////////////
	// retirement
	//////////////////////

	// head must be done, busy entries behind it wait
	assign retire_valid = (state_q[head_q] == entry_done);
	assign retire_fire = retire_valid && retire_ready;

	assign retire_arn = arn_q[head_q];
	assign retire_reg_write = reg_write_q[head_q];
	assign retire_prn = prn_q[head_q];
	assign retire_old_prn = old_prn_q[head_q];

	// superseded mapping goes back to the pool
	assign release_valid = retire_fire && reg_write_q[head_q];
	assign release_prn = old_prn_q[head_q];

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else begin
			if (rob.fire) begin
				tail_q <= tail_q + 1'b1;
			end
			if (retire_fire) begin
				head_q <= head_q + 1'b1;
			end
			if (rob.fire && !retire_fire) begin
				count_q <= count_q + 1'b1;
			end else if (retire_fire && !rob.fire) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	// entry states
	// tail, head and completion never name the same slot in one cycle
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < rob_depth; i++) begin
				state_q[i] <= entry_free;
			end
		end else begin
			if (rob.fire) begin
				state_q[tail_q] <= entry_busy;
			end
			// out-of-order finish
			if (complete_valid) begin
				state_q[complete_rob_idx] <= entry_done;
			end
			if (retire_fire) begin
				state_q[head_q] <= entry_free;
			end
		end
	end

	// payload captured on dispatch
	always_ff @(posedge clock) begin
		if (rob.fire) begin
			arn_q[tail_q] <= rob.arn;
			reg_write_q[tail_q] <= rob.reg_write;
			prn_q[tail_q] <= rob.new_prn;
			old_prn_q[tail_q] <= rob.old_prn;
		end
	end

	//////////////////////
	// checks
	//////////////////////

	// completion bus may only finish in-flight work
	a_complete_busy: assert property (@(posedge clock) disable iff (!rst_n)
		complete_valid |-> (state_q[complete_rob_idx] == entry_busy))
		else $error("completion named an entry that is not busy");

endmodule

/* logic/map_table.sv */
// map_table: speculative ARN to PRN mapping with identity contents after reset
module map_table (
	input logic clock,
	input logic rst_n,
	rename_if.map map
);

	import rename_pkg::*;

	// one PRN per architectural register
	prn_t map_q [num_arch_regs];

	logic map_write;

	//////////////////////
	// lookup
	//////////////////////

	// previous mapping of the destination
	// read before this cycle's update takes effect
	assign map.old_prn = map_q[map.arn];

	// non-writing instructions leave the table alone
	assign map_write = map.fire && map.reg_write;

	//////////////////////
	// update
	//////////////////////

	// ARN n starts out on PRN n
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_arch_regs; i++) begin
				map_q[i] <= prn_t'(i);
			end
		end else if (map_write) begin
			// newest producer of arn
			map_q[map.arn] <= map.new_prn;
		end
	end

	// a written destination must leave the identity range or come back from retirement
	// so the new PRN is never the one it replaces
	a_new_differs: assert property (@(posedge clock) disable iff (!rst_n)
		map_write |-> (map.new_prn != map.old_prn))
		else $error("rename reused the PRN being replaced");

endmodule

/* logic/free_list.sv */
// free_list: FIFO of unmapped physical registers, pop on dispatch and push on retirement
module free_list (
	input logic clock,
	input logic rst_n,
	rename_if.pool pool,
	output logic free_empty,
	input logic release_valid,
	input rename_pkg::prn_t release_prn
);

	import rename_pkg::*;

	// PRN storage
	prn_t slot_q [num_free];

	// read and write pointers
	free_idx_t head_q;
	free_idx_t tail_q;
	free_count_t count_q;

	logic pop;

	//////////////////////
	// control
	//////////////////////

	// only register-writing dispatches consume a PRN
	assign pop = pool.fire && pool.reg_write;

	assign free_empty = (count_q == '0);

	// head of the FIFO, valid whenever not empty
	assign pool.new_prn = slot_q[head_q];

	// pointers wrap on their own since num_free is a power of two
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			// full after reset
			tail_q <= '0;
			count_q <= free_count_t'(num_free);
		end else begin
			if (pop) begin
				head_q <= head_q + 1'b1;
			end
			if (release_valid) begin
				tail_q <= tail_q + 1'b1;
			end
			// pop and push together leave the count alone
			if (pop && !release_valid) begin
				count_q <= count_q - 1'b1;
			end else if (release_valid && !pop) begin
				count_q <= count_q + 1'b1;
			end
		end
	end

	// PRNs above the identity range start out free
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_free; i++) begin
				slot_q[i] <= prn_t'(num_arch_regs + i);
			end
		end else if (release_valid) begin
			slot_q[tail_q] <= release_prn;
		end
	end

	//////////////////////
	// checks
	//////////////////////

	// dispatch_ready in the reorder buffer must hold back on empty
	a_no_pop_empty: assert property (@(posedge clock) disable iff (!rst_n)
		pop |-> !free_empty)
		else $error("free list popped while empty");

	// releases can never outnumber outstanding allocations
	a_no_push_full: assert property (@(posedge clock) disable iff (!rst_n)
		release_valid |-> (count_q != free_count_t'(num_free)))
		else $error("free list pushed while full");

endmodule

/* logic/rename_if.sv */
// rename_if: per-dispatch rename data shared by reorder buffer, map table and free list
interface rename_if;

	import rename_pkg::*;

	// dispatch handshake completes this cycle
	logic fire;

	// destination register of the dispatching instruction
	arn_t arn;

	// instruction writes a register
	logic reg_write;

	// PRN taken from the free list head
	prn_t new_prn;

	// mapping of arn before this dispatch
	prn_t old_prn;

	// reorder buffer decides acceptance
	modport rob (output fire, input arn, input reg_write, input new_prn, input old_prn);

	// map table looks up and updates arn
	modport map (input fire, input arn, input reg_write, input new_prn, output old_prn);

	// free list hands out PRNs
	modport pool (input fire, input reg_write, output new_prn);

endinterface

/* logic/rename_pkg.sv */
// rename_pkg: register and buffer sizes, index types, reorder-buffer entry states
package rename_pkg;

	//////////////////////
	// sizes
	//////////////////////

	// architectural register file, identity mapped after reset
	localparam int num_arch_regs = 32;

	// physical register file
	localparam int num_phys_regs = 40;

	// PRNs left over once every ARN holds one
	localparam int num_free = num_phys_regs - num_arch_regs;

	// reorder-buffer entries
	localparam int rob_depth = 16;

	//////////////////////
	// index types
	//////////////////////

	// architectural register index
	typedef logic [$clog2(num_arch_regs)-1:0] arn_t;

	// physical register index
	typedef logic [$clog2(num_phys_regs)-1:0] prn_t;

	// reorder-buffer slot, wraps at rob_depth
	typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;

	// reorder-buffer occupancy, 0 to rob_depth
	typedef logic [$clog2(rob_depth+1)-1:0] rob_count_t;

	// free-list slot, wraps at num_free
	typedef logic [$clog2(num_free)-1:0] free_idx_t;

	// free-list occupancy, 0 to num_free
	typedef logic [$clog2(num_free+1)-1:0] free_count_t;

	//////////////////////
	// entry states
	//////////////////////

	// life of one reorder-buffer slot
	// free -> busy on dispatch
	// busy -> done on completion
	// done -> free on retirement
	typedef enum logic [1:0] {
		entry_free = 2'd0,
		entry_busy = 2'd1,
		entry_done = 2'd2
	} entry_state_t;

endpackage
